// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module tb_cpu_axi_bridge -o sim_tb
	-./obj_dir/sim_tb > sim.log 2>&1
	@cat sim.log
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: list.f
+incdir+logic
logic/bridge_pkg.sv
logic/axi_read_master.sv
logic/axi_write_master.sv
logic/mem_round_ctrl.sv
logic/cpu_axi_bridge.sv
tb/axi_mem_model.sv
tb/tb_cpu_axi_bridge.sv

// File: logic/axi_read_master.sv
`default_nettype none

`include "bridge_params.svh"

module axi_read_master (
	input  logic                      ACLK,
	input  logic                      ARESETn,
	input  logic                      start,
	input  logic [`BRIDGE_ADDR_W-1:0] addr,
	output logic                      done,
	output logic [`BRIDGE_DATA_W-1:0] rdata,
	output bridge_pkg::axi_ar_t       ar,
	output logic                      arvalid,
	input  logic                      arready,
	input  bridge_pkg::axi_r_t        r,
	input  logic                      rvalid,
	output logic                      rready
);
	import bridge_pkg::*;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA
	} rd_state_t;

	rd_state_t state;
	axi_ar_t   ar_q;

	// ==================================================
	// Sequencer
	// ==================================================
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state <= RD_IDLE;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				RD_IDLE: begin
					if (start) begin
						state <= RD_ADDR;
					end
				end
				RD_ADDR: begin
					if (arvalid && arready) begin
						state <= RD_DATA;
					end
				end
				RD_DATA: begin
					if (rvalid && rready) begin
						state <= RD_IDLE;
						done  <= 1'b1;
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	// Address held from start until the AR handshake
	always_ff @(posedge ACLK) begin
		if (state == RD_IDLE && start) begin
			ar_q <= '{addr: addr, prot: 3'b000};
		end
		if (rvalid && rready) begin
			rdata <= r.data;
		end
	end

	assign ar      = ar_q;
	assign arvalid = (state == RD_ADDR);
	assign rready  = (state == RD_DATA);

endmodule

`default_nettype wire

// File: logic/axi_write_master.sv
`default_nettype none

`include "bridge_params.svh"

module axi_write_master (
	input  logic                      ACLK,
	input  logic                      ARESETn,
	input  logic                      start,
	input  logic [`BRIDGE_ADDR_W-1:0] addr,
	input  logic [`BRIDGE_DATA_W-1:0] wdata,
	input  logic [`BRIDGE_STRB_W-1:0] web,
	output logic                      done,
	output bridge_pkg::axi_aw_t       aw,
	output logic                      awvalid,
	input  logic                      awready,
	output bridge_pkg::axi_w_t        w,
	output logic                      wvalid,
	input  logic                      wready,
	input  bridge_pkg::axi_b_t        b,
	input  logic                      bvalid,
	output logic                      bready
);
	import bridge_pkg::*;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_t;

	wr_state_t state;
	axi_aw_t   aw_q;
	axi_w_t    w_q;

	// ==================================================
	// Sequencer
	// ==================================================
	// Phases run strictly in order AW, W, B
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state <= WR_IDLE;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				WR_IDLE: begin
					if (start) begin
						state <= WR_ADDR;
					end
				end
				WR_ADDR: begin
					if (awvalid && awready) begin
						state <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (wvalid && wready) begin
						state <= WR_RESP;
					end
				end
				WR_RESP: begin
					// Response code is not checked
					if (bvalid && bready) begin
						state <= WR_IDLE;
						done  <= 1'b1;
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	// Operands captured at start, strobes are the inverted enables
	always_ff @(posedge ACLK) begin
		if (state == WR_IDLE && start) begin
			aw_q <= '{addr: addr, prot: 3'b000};
			w_q  <= '{data: wdata, strb: ~web};
		end
	end

	assign aw      = aw_q;
	assign w       = w_q;
	assign awvalid = (state == WR_ADDR);
	assign wvalid  = (state == WR_DATA);
	assign bready  = (state == WR_RESP);

endmodule

`default_nettype wire

// File: logic/bridge_params.svh
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// ==================================================
// Bus widths
// ==================================================
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32
`define BRIDGE_STRB_W 4

// ==================================================
// Address map
// ==================================================
// Upper 16 address bits of the read-only region
`define BRIDGE_ROM_TAG 16'h0000

`endif

// File: logic/bridge_pkg.sv
`default_nettype none

`include "bridge_params.svh"

package bridge_pkg;

	// Processor memory port, one word per request
	typedef struct packed {
		logic [`BRIDGE_ADDR_W-1:0] im_addr;
		logic [`BRIDGE_ADDR_W-1:0] dm_addr;
		logic [`BRIDGE_DATA_W-1:0] dm_wdata;
		logic [`BRIDGE_STRB_W-1:0] dm_web;
		logic                      dm_oe;
	} cpu_req_t;

	// ==================================================
	// AXI4-Lite channel payloads
	// ==================================================
	typedef struct packed {
		logic [`BRIDGE_ADDR_W-1:0] addr;
		logic [2:0]                prot;
	} axi_ar_t;

	typedef struct packed {
		logic [`BRIDGE_DATA_W-1:0] data;
		logic [1:0]                resp;
	} axi_r_t;

	typedef struct packed {
		logic [`BRIDGE_ADDR_W-1:0] addr;
		logic [2:0]                prot;
	} axi_aw_t;

	typedef struct packed {
		logic [`BRIDGE_DATA_W-1:0] data;
		logic [`BRIDGE_STRB_W-1:0] strb;
	} axi_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axi_b_t;

endpackage

`default_nettype wire

// File: logic/cpu_axi_bridge.sv
`default_nettype none

`include "bridge_params.svh"

module cpu_axi_bridge (
	input  logic                      ACLK,
	input  logic                      ARESETn,
	input  bridge_pkg::cpu_req_t      req,
	output logic [`BRIDGE_DATA_W-1:0] im_rdata,
	output logic [`BRIDGE_DATA_W-1:0] dm_rdata,
	output logic                      stall,
	// Fetch bus
	output bridge_pkg::axi_ar_t       ar_m0,
	output logic                      arvalid_m0,
	input  logic                      arready_m0,
	input  bridge_pkg::axi_r_t        r_m0,
	input  logic                      rvalid_m0,
	output logic                      rready_m0,
	// Data bus
	output bridge_pkg::axi_ar_t       ar_m1,
	output logic                      arvalid_m1,
	input  logic                      arready_m1,
	input  bridge_pkg::axi_r_t        r_m1,
	input  logic                      rvalid_m1,
	output logic                      rready_m1,
	output bridge_pkg::axi_aw_t       aw_m1,
	output logic                      awvalid_m1,
	input  logic                      awready_m1,
	output bridge_pkg::axi_w_t        w_m1,
	output logic                      wvalid_m1,
	input  logic                      wready_m1,
	input  bridge_pkg::axi_b_t        b_m1,
	input  logic                      bvalid_m1,
	output logic                      bready_m1
);
	logic                      fetch_start;
	logic [`BRIDGE_ADDR_W-1:0] fetch_addr;
	logic                      fetch_done;
	logic [`BRIDGE_DATA_W-1:0] fetch_data;
	logic                      load_start;
	logic [`BRIDGE_ADDR_W-1:0] load_addr;
	logic                      load_done;
	logic [`BRIDGE_DATA_W-1:0] load_data;
	logic                      store_start;
	logic [`BRIDGE_ADDR_W-1:0] store_addr;
	logic [`BRIDGE_DATA_W-1:0] store_data;
	logic [`BRIDGE_STRB_W-1:0] store_web;
	logic                      store_done;

	mem_round_ctrl u_ctrl (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.req         (req),
		.fetch_start (fetch_start),
		.fetch_addr  (fetch_addr),
		.fetch_done  (fetch_done),
		.fetch_data  (fetch_data),
		.load_start  (load_start),
		.load_addr   (load_addr),
		.load_done   (load_done),
		.load_data   (load_data),
		.store_start (store_start),
		.store_addr  (store_addr),
		.store_data  (store_data),
		.store_web   (store_web),
		.store_done  (store_done),
		.im_rdata    (im_rdata),
		.dm_rdata    (dm_rdata),
		.stall       (stall)
	);

	// ==================================================
	// Bus masters
	// ==================================================
	axi_read_master u_fetch (
		.ACLK    (ACLK),
		.ARESETn (ARESETn),
		.start   (fetch_start),
		.addr    (fetch_addr),
		.done    (fetch_done),
		.rdata   (fetch_data),
		.ar      (ar_m0),
		.arvalid (arvalid_m0),
		.arready (arready_m0),
		.r       (r_m0),
		.rvalid  (rvalid_m0),
		.rready  (rready_m0)
	);

	axi_read_master u_load (
		.ACLK    (ACLK),
		.ARESETn (ARESETn),
		.start   (load_start),
		.addr    (load_addr),
		.done    (load_done),
		.rdata   (load_data),
		.ar      (ar_m1),
		.arvalid (arvalid_m1),
		.arready (arready_m1),
		.r       (r_m1),
		.rvalid  (rvalid_m1),
		.rready  (rready_m1)
	);

	axi_write_master u_store (
		.ACLK    (ACLK),
		.ARESETn (ARESETn),
		.start   (store_start),
		.addr    (store_addr),
		.wdata   (store_data),
		.web     (store_web),
		.done    (store_done),
		.aw      (aw_m1),
		.awvalid (awvalid_m1),
		.awready (awready_m1),
		.w       (w_m1),
		.wvalid  (wvalid_m1),
		.wready  (wready_m1),
		.b       (b_m1),
		.bvalid  (bvalid_m1),
		.bready  (bready_m1)
	);

endmodule

`default_nettype wire

// File: logic/mem_round_ctrl.sv
`default_nettype none

`include "bridge_params.svh"

module mem_round_ctrl (
	input  logic                      ACLK,
	input  logic                      ARESETn,
	input  bridge_pkg::cpu_req_t      req,
	output logic                      fetch_start,
	output logic [`BRIDGE_ADDR_W-1:0] fetch_addr,
	input  logic                      fetch_done,
	input  logic [`BRIDGE_DATA_W-1:0] fetch_data,
	output logic                      load_start,
	output logic [`BRIDGE_ADDR_W-1:0] load_addr,
	input  logic                      load_done,
	input  logic [`BRIDGE_DATA_W-1:0] load_data,
	output logic                      store_start,
	output logic [`BRIDGE_ADDR_W-1:0] store_addr,
	output logic [`BRIDGE_DATA_W-1:0] store_data,
	output logic [`BRIDGE_STRB_W-1:0] store_web,
	input  logic                      store_done,
	output logic [`BRIDGE_DATA_W-1:0] im_rdata,
	output logic [`BRIDGE_DATA_W-1:0] dm_rdata,
	output logic                      stall
);
	// High when a new round begins on the next edge
	logic idle_q;
	logic fetch_pend;
	logic data_pend;
	logic is_store;
	logic rom_hit;
	logic do_store;
	logic do_load;
	logic fetch_left;
	logic data_left;

	// ==================================================
	// Request decode
	// ==================================================
	assign is_store = (req.dm_web != {`BRIDGE_STRB_W{1'b1}});
	assign rom_hit  = (req.dm_addr[`BRIDGE_ADDR_W-1 -: 16] == `BRIDGE_ROM_TAG);
	// Stores into ROM are dropped, a set load enable still wins then
	assign do_store = is_store && !rom_hit;
	assign do_load  = !do_store && req.dm_oe;

	assign fetch_left = fetch_pend && !fetch_done;
	assign data_left  = data_pend && !(load_done || store_done);

	// ==================================================
	// Round state
	// ==================================================
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			idle_q      <= 1'b1;
			stall       <= 1'b1;
			fetch_pend  <= 1'b0;
			data_pend   <= 1'b0;
			fetch_start <= 1'b0;
			load_start  <= 1'b0;
			store_start <= 1'b0;
		end else begin
			fetch_start <= 1'b0;
			load_start  <= 1'b0;
			store_start <= 1'b0;
			if (idle_q) begin
				idle_q      <= 1'b0;
				stall       <= 1'b1;
				fetch_pend  <= 1'b1;
				data_pend   <= do_store || do_load;
				fetch_start <= 1'b1;
				load_start  <= do_load;
				store_start <= do_store;
			end else begin
				fetch_pend <= fetch_left;
				data_pend  <= data_left;
				if (!fetch_left && !data_left) begin
					stall  <= 1'b0;
					idle_q <= 1'b1;
				end
			end
		end
	end

	// Returned words, dm_rdata only moves on a load
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			im_rdata <= '0;
			dm_rdata <= '0;
		end else begin
			if (fetch_done) begin
				im_rdata <= fetch_data;
			end
			if (load_done) begin
				dm_rdata <= load_data;
			end
		end
	end

	// req is held stable for the whole round
	assign fetch_addr = req.im_addr;
	assign load_addr  = req.dm_addr;
	assign store_addr = req.dm_addr;
	assign store_data = req.dm_wdata;
	assign store_web  = req.dm_web;

endmodule

`default_nettype wire

// File: tb/axi_mem_model.sv
`default_nettype none

`include "bridge_params.svh"

module axi_mem_model (
	input  logic                 ACLK,
	input  logic                 ARESETn,
	input  logic                 rand_en,
	input  bridge_pkg::axi_ar_t  ar,
	input  logic                 arvalid,
	output logic                 arready,
	output bridge_pkg::axi_r_t   r,
	output logic                 rvalid,
	input  logic                 rready,
	input  bridge_pkg::axi_aw_t  aw,
	input  logic                 awvalid,
	output logic                 awready,
	input  bridge_pkg::axi_w_t   w,
	input  logic                 wvalid,
	output logic                 wready,
	output bridge_pkg::axi_b_t   b,
	output logic                 bvalid,
	input  logic                 bready,
	output int                   aw_count
);
	timeunit 1ns;
	timeprecision 1ps;
	import bridge_pkg::*;

	logic [`BRIDGE_DATA_W-1:0] mem [logic [`BRIDGE_ADDR_W-1:0]];
	logic [31:0] lfsr = 32'ha912;
	logic [1:0]  ar_cnt = 2'd0;
	logic [1:0]  r_cnt = 2'd0;
	logic [1:0]  aw_cnt = 2'd0;
	logic [1:0]  w_cnt = 2'd0;
	logic [1:0]  b_cnt = 2'd0;
	logic        r_pend = 1'b0;
	logic        b_pend = 1'b0;
	logic [`BRIDGE_ADDR_W-1:0] rd_addr = '0;
	logic [`BRIDGE_ADDR_W-1:0] wr_addr = '0;
	logic        arready_q = 1'b0;
	logic        rvalid_q = 1'b0;
	logic        awready_q = 1'b0;
	logic        wready_q = 1'b0;
	logic        bvalid_q = 1'b0;
	axi_r_t      r_q = '0;
	axi_b_t      b_q = '0;
	int          aw_count_q = 0;
	logic        arready_d = 1'b0;
	logic        rvalid_d = 1'b0;
	logic        awready_d = 1'b0;
	logic        wready_d = 1'b0;
	logic        bvalid_d = 1'b0;
	axi_r_t      r_d = '0;
	axi_b_t      b_d = '0;

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Ready or valid delay of 0 to 3 cycles from two LFSR bits
	function automatic logic [1:0] draw_delay();
		logic [1:0] d;
		d = 2'd0;
		if (rand_en) begin
			lfsr = lfsr_next(lfsr);
			d[0] = lfsr[0];
			lfsr = lfsr_next(lfsr);
			d[1] = lfsr[0];
		end
		return d;
	endfunction

	function automatic logic [`BRIDGE_DATA_W-1:0] read_word(input logic [`BRIDGE_ADDR_W-1:0] a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return a ^ 32'h5a5a0000;
	endfunction

	always @(posedge ACLK) begin
		logic [`BRIDGE_DATA_W-1:0] word;
		if (!ARESETn) begin
			arready_q  <= 1'b0;
			rvalid_q   <= 1'b0;
			awready_q  <= 1'b0;
			wready_q   <= 1'b0;
			bvalid_q   <= 1'b0;
			r_pend     <= 1'b0;
			b_pend     <= 1'b0;
			aw_count_q <= 0;
		end else begin
			// ==================================================
			// Read side
			// ==================================================
			if (arvalid && arready_q) begin
				arready_q <= 1'b0;
				ar_cnt    <= draw_delay();
				rd_addr   <= ar.addr;
				r_pend    <= 1'b1;
				r_cnt     <= draw_delay();
			end else if (arvalid) begin
				if (ar_cnt == 2'd0) arready_q <= 1'b1;
				else ar_cnt <= ar_cnt - 2'd1;
			end
			if (rvalid_q && rready) begin
				rvalid_q <= 1'b0;
			end else if (r_pend && !rvalid_q) begin
				if (r_cnt == 2'd0) begin
					rvalid_q <= 1'b1;
					r_q      <= '{data: read_word(rd_addr), resp: 2'b00};
					r_pend   <= 1'b0;
				end else begin
					r_cnt <= r_cnt - 2'd1;
				end
			end

			// ==================================================
			// Write side
			// ==================================================
			if (awvalid && awready_q) begin
				awready_q  <= 1'b0;
				aw_cnt     <= draw_delay();
				wr_addr    <= aw.addr;
				aw_count_q <= aw_count_q + 1;
			end else if (awvalid) begin
				if (aw_cnt == 2'd0) awready_q <= 1'b1;
				else aw_cnt <= aw_cnt - 2'd1;
			end
			if (wvalid && wready_q) begin
				wready_q <= 1'b0;
				w_cnt    <= draw_delay();
				// Byte merge by strobe
				word = read_word(wr_addr);
				for (int i = 0; i < `BRIDGE_STRB_W; i++) begin
					if (w.strb[i]) word[8*i +: 8] = w.data[8*i +: 8];
				end
				mem[wr_addr] = word;
				b_pend <= 1'b1;
				b_cnt  <= draw_delay();
			end else if (wvalid) begin
				if (w_cnt == 2'd0) wready_q <= 1'b1;
				else w_cnt <= w_cnt - 2'd1;
			end
			if (bvalid_q && bready) begin
				bvalid_q <= 1'b0;
			end else if (b_pend && !bvalid_q) begin
				if (b_cnt == 2'd0) begin
					bvalid_q <= 1'b1;
					b_q      <= '{resp: 2'b00};
					b_pend   <= 1'b0;
				end else begin
					b_cnt <= b_cnt - 2'd1;
				end
			end
		end
	end

	// Slave outputs move on the falling edge
	always @(negedge ACLK) begin
		arready_d <= arready_q;
		rvalid_d  <= rvalid_q;
		r_d       <= r_q;
		awready_d <= awready_q;
		wready_d  <= wready_q;
		bvalid_d  <= bvalid_q;
		b_d       <= b_q;
	end

	assign arready  = arready_d;
	assign rvalid   = rvalid_d;
	assign r        = r_d;
	assign awready  = awready_d;
	assign wready   = wready_d;
	assign bvalid   = bvalid_d;
	assign b        = b_d;
	assign aw_count = aw_count_q;

endmodule

`default_nettype wire

// File: tb/tb_cpu_axi_bridge.sv
`default_nettype none

`include "bridge_params.svh"

module tb_cpu_axi_bridge;
	timeunit 1ns;
	timeprecision 1ps;
	import bridge_pkg::*;

	logic     ACLK = 1'b0;
	logic     ARESETn = 1'b0;
	logic     rand_en = 1'b0;
	cpu_req_t req = '{im_addr: '0, dm_addr: '0, dm_wdata: '0, dm_web: 4'hf, dm_oe: 1'b0};
	logic [`BRIDGE_DATA_W-1:0] im_rdata;
	logic [`BRIDGE_DATA_W-1:0] dm_rdata;
	logic     stall;
	axi_ar_t  ar_m0, ar_m1;
	axi_r_t   r_m0, r_m1;
	axi_aw_t  aw_m1;
	axi_w_t   w_m1;
	axi_b_t   b_m1;
	logic     arvalid_m0, arready_m0, rvalid_m0, rready_m0;
	logic     arvalid_m1, arready_m1, rvalid_m1, rready_m1;
	logic     awvalid_m1, awready_m1, wvalid_m1, wready_m1, bvalid_m1, bready_m1;
	logic     unused_awready, unused_wready, unused_bvalid;
	axi_b_t   unused_b;
	int       fetch_aw_count;
	int       data_aw_count;

	// Expected values of the round in flight
	logic [`BRIDGE_DATA_W-1:0] exp_im = '0;
	logic [`BRIDGE_DATA_W-1:0] exp_dm = '0;
	int       exp_aw = 0;
	int       total_stores = 0;
	int       rel_cycles = 0;
	logic [`BRIDGE_DATA_W-1:0] shadow [logic [`BRIDGE_ADDR_W-1:0]];
	logic [31:0] rng = 32'ha912;

	// Payload hold tracking for the valid stability checks
	logic     ar0_hold = 1'b0, ar1_hold = 1'b0, aw1_hold = 1'b0, w1_hold = 1'b0;
	axi_ar_t  ar0_prev = '0, ar1_prev = '0;
	axi_aw_t  aw1_prev = '0;
	axi_w_t   w1_prev = '0;

	always #50 ACLK = ~ACLK;

	cpu_axi_bridge i_dut (
		.ACLK(ACLK), .ARESETn(ARESETn), .req(req),
		.im_rdata(im_rdata), .dm_rdata(dm_rdata), .stall(stall),
		.ar_m0(ar_m0), .arvalid_m0(arvalid_m0), .arready_m0(arready_m0),
		.r_m0(r_m0), .rvalid_m0(rvalid_m0), .rready_m0(rready_m0),
		.ar_m1(ar_m1), .arvalid_m1(arvalid_m1), .arready_m1(arready_m1),
		.r_m1(r_m1), .rvalid_m1(rvalid_m1), .rready_m1(rready_m1),
		.aw_m1(aw_m1), .awvalid_m1(awvalid_m1), .awready_m1(awready_m1),
		.w_m1(w_m1), .wvalid_m1(wvalid_m1), .wready_m1(wready_m1),
		.b_m1(b_m1), .bvalid_m1(bvalid_m1), .bready_m1(bready_m1)
	);

	// Fetch memory with its write side tied off
	axi_mem_model u_fetch_mem (
		.ACLK(ACLK), .ARESETn(ARESETn), .rand_en(rand_en),
		.ar(ar_m0), .arvalid(arvalid_m0), .arready(arready_m0),
		.r(r_m0), .rvalid(rvalid_m0), .rready(rready_m0),
		.aw('0), .awvalid(1'b0), .awready(unused_awready),
		.w('0), .wvalid(1'b0), .wready(unused_wready),
		.b(unused_b), .bvalid(unused_bvalid), .bready(1'b0),
		.aw_count(fetch_aw_count)
	);

	axi_mem_model u_data_mem (
		.ACLK(ACLK), .ARESETn(ARESETn), .rand_en(rand_en),
		.ar(ar_m1), .arvalid(arvalid_m1), .arready(arready_m1),
		.r(r_m1), .rvalid(rvalid_m1), .rready(rready_m1),
		.aw(aw_m1), .awvalid(awvalid_m1), .awready(awready_m1),
		.w(w_m1), .wvalid(wvalid_m1), .wready(wready_m1),
		.b(b_m1), .bvalid(bvalid_m1), .bready(bready_m1),
		.aw_count(data_aw_count)
	);

	always @(posedge ACLK) begin
		if (!ARESETn) rel_cycles <= 0;
		else if (rel_cycles < 2) rel_cycles <= rel_cycles + 1;
		ar0_hold <= arvalid_m0 && !arready_m0;
		ar1_hold <= arvalid_m1 && !arready_m1;
		aw1_hold <= awvalid_m1 && !awready_m1;
		w1_hold  <= wvalid_m1 && !wready_m1;
		ar0_prev <= ar_m0;
		ar1_prev <= ar_m1;
		aw1_prev <= aw_m1;
		w1_prev  <= w_m1;
	end

	task automatic abort_run();
		$display("Test failed");
		$fatal(1);
	endtask

	// ==================================================
	// Checks
	// ==================================================
	a_reset_idle: assert property (@(negedge ACLK) (rel_cycles < 2) |->
		(stall && !arvalid_m0 && !rready_m0 && !arvalid_m1 && !rready_m1 &&
		 !awvalid_m1 && !wvalid_m1 && !bready_m1))
	else begin
		$display("MISMATCH t=%0t %s expected 10000000 actual %b", $time,
			"stall,arvalid_m0,rready_m0,arvalid_m1,rready_m1,awvalid_m1,wvalid_m1,bready_m1",
			{stall, arvalid_m0, rready_m0, arvalid_m1, rready_m1, awvalid_m1, wvalid_m1,
			 bready_m1});
		abort_run();
	end

	a_im_rdata: assert property (@(negedge ACLK) !stall |-> im_rdata == exp_im)
	else begin
		$display("MISMATCH t=%0t im_rdata expected %h actual %h", $time, $sampled(exp_im),
			$sampled(im_rdata));
		abort_run();
	end

	a_dm_rdata: assert property (@(negedge ACLK) !stall |-> dm_rdata == exp_dm)
	else begin
		$display("MISMATCH t=%0t dm_rdata expected %h actual %h", $time, $sampled(exp_dm),
			$sampled(dm_rdata));
		abort_run();
	end

	a_aw_count: assert property (@(negedge ACLK) !stall |-> data_aw_count == exp_aw)
	else begin
		$display("MISMATCH t=%0t aw_count expected %0d actual %0d", $time, $sampled(exp_aw),
			$sampled(data_aw_count));
		abort_run();
	end

	a_ar0_hold: assert property (@(negedge ACLK) ar0_hold |-> arvalid_m0 && ar_m0 == ar0_prev)
	else begin
		$display("MISMATCH t=%0t ar_m0 expected 1/%h actual %b/%h", $time, ar0_prev,
			arvalid_m0, ar_m0);
		abort_run();
	end

	a_ar1_hold: assert property (@(negedge ACLK) ar1_hold |-> arvalid_m1 && ar_m1 == ar1_prev)
	else begin
		$display("MISMATCH t=%0t ar_m1 expected 1/%h actual %b/%h", $time, ar1_prev,
			arvalid_m1, ar_m1);
		abort_run();
	end

	a_aw1_hold: assert property (@(negedge ACLK) aw1_hold |-> awvalid_m1 && aw_m1 == aw1_prev)
	else begin
		$display("MISMATCH t=%0t aw_m1 expected 1/%h actual %b/%h", $time, aw1_prev,
			awvalid_m1, aw_m1);
		abort_run();
	end

	a_w1_hold: assert property (@(negedge ACLK) w1_hold |-> wvalid_m1 && w_m1 == w1_prev)
	else begin
		$display("MISMATCH t=%0t w_m1 expected 1/%h actual %b/%h", $time, w1_prev,
			wvalid_m1, w_m1);
		abort_run();
	end

	// ==================================================
	// Stimulus
	// ==================================================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			rng = lfsr_next(rng);
			v = {v[30:0], rng[0]};
		end
		return v;
	endfunction

	function automatic logic [`BRIDGE_DATA_W-1:0] shadow_read(input logic [`BRIDGE_ADDR_W-1:0] a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return a ^ 32'h5a5a0000;
	endfunction

	// Drives one round on the falling edge and waits for its stall-low cycle
	task automatic run_round(input cpu_req_t rq);
		logic do_store;
		logic do_load;
		logic [`BRIDGE_DATA_W-1:0] word;
		int   n;
		do_store = (rq.dm_web != 4'hf) && (rq.dm_addr[31:16] != 16'h0000);
		do_load  = !do_store && rq.dm_oe;
		req    <= rq;
		// Fetch memory is never written
		exp_im <= rq.im_addr ^ 32'h5a5a0000;
		if (do_load) exp_dm <= shadow_read(rq.dm_addr);
		if (do_store) begin
			word = shadow_read(rq.dm_addr);
			for (int i = 0; i < 4; i++) begin
				if (!rq.dm_web[i]) word[8*i +: 8] = rq.dm_wdata[8*i +: 8];
			end
			shadow[rq.dm_addr] = word;
			total_stores = total_stores + 1;
		end
		exp_aw <= total_stores;
		n = 0;
		do begin
			@(negedge ACLK);
			n = n + 1;
		end while (stall && n < 200);
		if (stall) begin
			$display("Timeout: stall never went low within 200 cycles at t=%0t", $time);
			abort_run();
		end
	endtask

	function automatic cpu_req_t make_req(input logic [31:0] im, input logic [31:0] dm,
		input logic [31:0] wd, input logic [3:0] web, input logic oe);
		return '{im_addr: im, dm_addr: dm, dm_wdata: wd, dm_web: web, dm_oe: oe};
	endfunction

	function automatic cpu_req_t random_req();
		logic [15:0] upper;
		logic [3:0]  web;
		logic [31:0] im;
		logic [31:0] dm;
		logic [31:0] wd;
		logic [31:0] bits;
		logic        oe;
		bits  = take_bits(14);
		im    = {16'h0000, bits[13:0], 2'b00};
		bits  = take_bits(2);
		upper = (bits[1:0] == 2'd0) ? 16'h0000 : 16'h0001;
		bits  = take_bits(6);
		dm    = {upper, 8'h00, bits[5:0], 2'b00};
		bits  = take_bits(2);
		web   = 4'hf;
		if (bits[1:0] == 2'd0) begin
			bits = take_bits(4);
			web  = bits[3:0];
		end
		wd    = take_bits(32);
		bits  = take_bits(1);
		oe    = bits[0];
		return make_req(im, dm, wd, web, oe);
	endfunction

	initial begin
		repeat (5) @(negedge ACLK);
		ARESETn <= 1'b1;
		for (int phase = 0; phase < 2; phase++) begin
			rand_en <= phase[0];
			run_round(make_req(32'h0000_0100, 32'h0001_0010, 32'h0, 4'hf, 1'b0));
			run_round(make_req(32'h0000_0104, 32'h0001_0010, 32'h0, 4'hf, 1'b1));
			run_round(make_req(32'h0000_0108, 32'h0001_0010, 32'h11223344, 4'b1010, 1'b0));
			run_round(make_req(32'h0000_010c, 32'h0001_0010, 32'h0, 4'hf, 1'b1));
			run_round(make_req(32'h0000_0110, 32'h0000_0040, 32'hdeadbeef, 4'h0, 1'b0));
			run_round(make_req(32'h0000_0114, 32'h0000_0040, 32'h0, 4'hf, 1'b1));
			for (int k = 0; k < 35; k++) begin
				run_round(random_req());
			end
		end
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire
